//--- design/core_div.sv
`default_nettype none

module core_div (
  input  logic                   clk_i,
  input  logic                   rst,
  input  logic                   valid_i,
  input  ppu_pkg::posit_fields_t op_a_i,
  input  ppu_pkg::posit_fields_t op_b_i,
  output ppu_pkg::div_result_t   result_o
);

  // position of the ones digit in the mantissa product
  localparam int ONE_BIT = ppu_pkg::MANT_DIV_SIZE - 2;
  localparam int QM_W    = ppu_pkg::MANT_SIZE + 1;

  ppu_pkg::recip_t    x0;
  ppu_pkg::nr_recip_t x1;

  logic               valid_q;
  logic               nar_q;
  logic               zero_q;
  logic               sign_q;
  ppu_pkg::exponent_t te_diff_q;
  ppu_pkg::mant_t     mant_a_q;

  logic [ppu_pkg::MANT_DIV_SIZE-1:0] mant_div;
  logic [ppu_pkg::MANT_DIV_SIZE-1:0] mant_norm;
  logic                              below_one;

  mant_recip_seed i_mant_recip_seed (
    .mant_i  (op_b_i.mant),
    .recip_o (x0)
  );

  newton_raphson i_newton_raphson (
    .clk_i (clk_i),
    .rst   (rst),
    .num_i (op_b_i.mant),
    .x0_i  (x0),
    .x1_o  (x1)
  );

  // stage two registers, aligned with the refined reciprocal
  always_ff @(posedge clk_i) begin
    if (rst) begin
      valid_q <= 1'b0;
      nar_q   <= 1'b0;
      zero_q  <= 1'b0;
    end else begin
      valid_q <= valid_i;
      nar_q   <= op_a_i.is_nar | op_b_i.is_nar | op_b_i.is_zero;
      zero_q  <= op_a_i.is_zero;
    end
  end

  always_ff @(posedge clk_i) begin
    sign_q    <= op_a_i.sign ^ op_b_i.sign;
    te_diff_q <= op_a_i.te - op_b_i.te;
    mant_a_q  <= op_a_i.mant;
  end

  always_comb begin
    mant_div  = mant_a_q * x1;
    // quotient of two mantissas lies in (0.5, 2)
    below_one = ~mant_div[ONE_BIT];
    mant_norm = below_one ? mant_div << 1 : mant_div;

    result_o.valid   = valid_q;
    result_o.is_nar  = nar_q;
    result_o.is_zero = zero_q & ~nar_q;
    result_o.sign    = sign_q;
    result_o.te      = below_one ? te_diff_q - 1 : te_diff_q;
    result_o.mant    = mant_norm[ONE_BIT -: QM_W];
    result_o.sticky  = |mant_norm[ONE_BIT-QM_W:0];
  end

  // the refined reciprocal has to be close enough to keep the quotient normalised
  a_norm_mant: assert property (@(posedge clk_i) disable iff (rst)
    result_o.valid && !result_o.is_nar && !result_o.is_zero |-> result_o.mant[QM_W-1]);

endmodule

`default_nettype wire

//--- design/mant_recip_seed.sv
`default_nettype none

module mant_recip_seed (
  input  ppu_pkg::mant_t  mant_i,
  output ppu_pkg::recip_t recip_o
);

  localparam int FRAC_W  = ppu_pkg::MANT_SIZE - 1;
  localparam int OFS_W   = FRAC_W - 2;
  localparam int SEED_W  = 16;
  localparam int SLOPE_W = 12;
  localparam int PROD_W  = SLOPE_W + OFS_W;
  // slope * offset is scaled by 2^-(SLOPE_W + FRAC_W), the seed by 2^-SEED_W
  localparam int PROD_SHIFT = SLOPE_W + FRAC_W - SEED_W;

  logic [SEED_W-1:0]  base;
  logic [SLOPE_W-1:0] slope;
  logic [PROD_W-1:0]  prod;
  logic [SEED_W-1:0]  seed;

  always_comb begin
    // minimax lines for 1/m over quarters of [1, 2)
    case (mant_i[FRAC_W-1 -: 2])
      2'd0: begin
        base  = 16'd65171;
        slope = 12'd3277;
      end
      2'd1: begin
        base  = 16'd52230;
        slope = 12'd2185;
      end
      2'd2: begin
        base  = 16'd43570;
        slope = 12'd1560;
      end
      default: begin
        base  = 16'd37371;
        slope = 12'd1170;
      end
    endcase

    prod = slope * mant_i[OFS_W-1:0];
    seed = base - SEED_W'(prod >> PROD_SHIFT);

    // 1/1 needs the integer bit, every other seed is below one
    if (mant_i[FRAC_W-1:0] == '0) begin
      recip_o = {1'b1, {(ppu_pkg::RECIP_SIZE - 1){1'b0}}};
    end else begin
      recip_o = {1'b0, seed, {(ppu_pkg::RECIP_SIZE - 1 - SEED_W){1'b0}}};
    end
  end

endmodule

`default_nettype wire

//--- design/newton_raphson.sv
`default_nettype none

module newton_raphson (
  input  logic               clk_i,
  input  logic               rst,
  input  ppu_pkg::mant_t     num_i,
  input  ppu_pkg::recip_t    x0_i,
  output ppu_pkg::nr_recip_t x1_o
);

  localparam int PROD_W = ppu_pkg::MANT_SIZE + ppu_pkg::RECIP_SIZE;
  localparam int CORR_W = ppu_pkg::NR_SIZE + 2;
  localparam int X1_W   = ppu_pkg::RECIP_SIZE + CORR_W;

  localparam ppu_pkg::mant_t     MANT_ONE  = {1'b1, {(ppu_pkg::MANT_SIZE - 1){1'b0}}};
  localparam ppu_pkg::nr_recip_t RECIP_ONE = {1'b1, {(ppu_pkg::NR_SIZE - 1){1'b0}}};

  logic [PROD_W-1:0] num_x0;
  logic [PROD_W-1:0] corr;
  logic [CORR_W-1:0] corr_t;
  logic [X1_W-1:0]   x1_full;

  always_comb begin
    // num * x0 has PROD_W-2 fraction bits, so 2.0 sits in the top bit
    num_x0  = num_i * x0_i;
    corr    = {1'b1, {(PROD_W - 1){1'b0}}} - num_x0;
    // keep NR_SIZE fraction bits of the correction term
    corr_t  = corr[PROD_W-1 -: CORR_W];
    x1_full = x0_i * corr_t;
  end

  always_ff @(posedge clk_i) begin
    if (rst) begin
      x1_o <= '0;
    end else begin
      x1_o <= x1_full[ppu_pkg::RECIP_SIZE +: ppu_pkg::NR_SIZE];
    end
  end

  // a unit divisor comes out of seed and refinement as exactly one
  a_unit_recip: assert property (@(posedge clk_i) disable iff (rst)
    num_i == MANT_ONE |=> x1_o == RECIP_ONE);

endmodule

`default_nettype wire

//--- design/posit_decode.sv
`default_nettype none

module posit_decode (
  input  logic                   clk_i,
  input  logic                   rst,
  input  logic                   valid_i,
  input  ppu_pkg::posit_t        posit_i,
  output logic                   valid_o,
  output ppu_pkg::posit_fields_t fields_o
);

  localparam int BODY_W = ppu_pkg::N - 1;
  localparam int RUN_W  = $clog2(BODY_W + 1);

  ppu_pkg::posit_fields_t fields_d;
  ppu_pkg::posit_t        abs_word;
  logic [BODY_W-1:0]      body;
  logic [BODY_W-1:0]      run_bits;
  logic [BODY_W-1:0]      rest;
  logic [RUN_W-1:0]       run;
  logic                   regime_bit;
  logic [ppu_pkg::ES-1:0] exp_bits;
  ppu_pkg::exponent_t     run_te;
  ppu_pkg::exponent_t     k;

  always_comb begin
    abs_word   = posit_i[ppu_pkg::N-1] ? -posit_i : posit_i;
    body       = abs_word[BODY_W-1:0];
    regime_bit = body[BODY_W-1];

    // a run of ones is counted as a run of zeros on the inverted body
    run_bits = regime_bit ? ~body : body;
    run      = RUN_W'(BODY_W);
    for (int i = 0; i < BODY_W; i++) begin
      if (run_bits[i]) begin
        run = RUN_W'(BODY_W - 1 - i);
      end
    end

    // drop the regime run and its terminator
    rest     = body << (run + 1);
    exp_bits = rest[BODY_W-1 -: ppu_pkg::ES];
    run_te   = ppu_pkg::exponent_t'(run);
    k        = regime_bit ? run_te - 1 : -run_te;

    fields_d.is_zero = (posit_i == '0);
    fields_d.is_nar  = (posit_i == ppu_pkg::NAR);
    fields_d.sign    = posit_i[ppu_pkg::N-1];
    fields_d.te      = (k <<< ppu_pkg::ES) + ppu_pkg::exponent_t'(exp_bits);
    fields_d.mant    = {1'b1, rest[BODY_W-1-ppu_pkg::ES -: ppu_pkg::MANT_SIZE-1]};
  end

  always_ff @(posedge clk_i) begin
    if (rst) begin
      valid_o  <= 1'b0;
      fields_o <= '0;
    end else begin
      valid_o  <= valid_i;
      fields_o <= fields_d;
    end
  end

endmodule

`default_nettype wire

//--- design/posit_div_top.sv
`default_nettype none

module posit_div_top (
  input  logic            clk_i,
  input  logic            rst,
  input  logic            valid_i,
  input  ppu_pkg::posit_t dividend_i,
  input  ppu_pkg::posit_t divisor_i,
  output logic            valid_o,
  output ppu_pkg::posit_t quotient_o
);

  logic                   dec_valid;
  ppu_pkg::posit_fields_t fields_a;
  ppu_pkg::posit_fields_t fields_b;
  ppu_pkg::div_result_t   result;

  // the dividend decoder carries the valid strobe
  posit_decode i_decode_a (
    .clk_i    (clk_i),
    .rst      (rst),
    .valid_i  (valid_i),
    .posit_i  (dividend_i),
    .valid_o  (dec_valid),
    .fields_o (fields_a)
  );

  posit_decode i_decode_b (
    .clk_i    (clk_i),
    .rst      (rst),
    .valid_i  (valid_i),
    .posit_i  (divisor_i),
    .valid_o  (),
    .fields_o (fields_b)
  );

  core_div i_core_div (
    .clk_i    (clk_i),
    .rst      (rst),
    .valid_i  (dec_valid),
    .op_a_i   (fields_a),
    .op_b_i   (fields_b),
    .result_o (result)
  );

  posit_encode i_posit_encode (
    .clk_i    (clk_i),
    .rst      (rst),
    .result_i (result),
    .valid_o  (valid_o),
    .posit_o  (quotient_o)
  );

endmodule

`default_nettype wire

//--- design/posit_encode.sv
`default_nettype none

module posit_encode (
  input  logic                 clk_i,
  input  logic                 rst,
  input  ppu_pkg::div_result_t result_i,
  output logic                 valid_o,
  output ppu_pkg::posit_t      posit_o
);

  localparam int BODY_W = ppu_pkg::N - 1;
  localparam int RUN_W  = $clog2(BODY_W + 1);
  // terminator, exponent bits, fraction and guard
  localparam int TAIL_W = 1 + ppu_pkg::ES + ppu_pkg::MANT_SIZE;
  localparam int EXT_W  = BODY_W + TAIL_W + 1;

  ppu_pkg::exponent_t te_c;
  ppu_pkg::exponent_t k;
  ppu_pkg::exponent_t run_te;
  logic [RUN_W-1:0]   run;
  logic               regime_bit;
  logic [TAIL_W-1:0]  tail;
  logic [EXT_W-1:0]   ext;
  logic [EXT_W-1:0]   shifted;
  logic [BODY_W-1:0]  body;
  logic [BODY_W-1:0]  body_rnd;
  logic               round_bit;
  logic               sticky;
  logic               round_up;
  ppu_pkg::posit_t    word;

  always_comb begin
    // out of range results saturate to maxpos or minpos
    if (result_i.te > ppu_pkg::TE_MAX) begin
      te_c = ppu_pkg::exponent_t'(ppu_pkg::TE_MAX);
    end else if (result_i.te < -ppu_pkg::TE_MAX) begin
      te_c = ppu_pkg::exponent_t'(-ppu_pkg::TE_MAX);
    end else begin
      te_c = result_i.te;
    end

    k          = te_c >>> ppu_pkg::ES;
    regime_bit = ~k[ppu_pkg::TE_BITS-1];
    run_te     = regime_bit ? k + 1 : -k;
    run        = run_te[RUN_W-1:0];

    // shift the tail right by the run length and fill with the regime bit
    tail    = {~regime_bit, te_c[ppu_pkg::ES-1:0], result_i.mant[ppu_pkg::MANT_SIZE-1:0]};
    ext     = {tail, {(EXT_W - TAIL_W){1'b0}}};
    shifted = ext >> run;
    if (regime_bit) begin
      shifted = shifted | ~({EXT_W{1'b1}} >> run);
    end

    body      = shifted[EXT_W-1 -: BODY_W];
    round_bit = shifted[EXT_W-1-BODY_W];
    sticky    = (|shifted[EXT_W-2-BODY_W:0]) | result_i.sticky;

    // round to nearest even; body is never zero, and at maxpos the round bit
    // is the terminator, so this cannot reach zero or NaR
    round_up = round_bit & (sticky | body[0]);
    body_rnd = body + round_up;

    word = {1'b0, body_rnd};
    if (result_i.sign) begin
      word = -word;
    end
    if (result_i.is_nar) begin
      word = ppu_pkg::NAR;
    end else if (result_i.is_zero) begin
      word = '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst) begin
      valid_o <= 1'b0;
      posit_o <= '0;
    end else begin
      valid_o <= result_i.valid;
      if (result_i.valid) begin
        posit_o <= word;
      end
    end
  end

  // NaR and zero only ever come from a special case flagged upstream
  a_no_special_round: assert property (@(posedge clk_i) disable iff (rst)
    valid_o && !$past(result_i.is_nar) && !$past(result_i.is_zero)
      |-> posit_o != ppu_pkg::NAR && posit_o != '0);

endmodule

`default_nettype wire

//--- design/ppu_pkg.sv
`default_nettype none

package ppu_pkg;

  // posit format
  localparam int N  = 16;
  localparam int ES = 1;

  // mantissa with the hidden bit
  localparam int MANT_SIZE     = N - ES - 2 + 1;
  localparam int RECIP_SIZE    = 3 * MANT_SIZE - 4;
  localparam int NR_SIZE       = 2 * MANT_SIZE;
  localparam int MANT_DIV_SIZE = MANT_SIZE + NR_SIZE;

  // total exponent is regime * 2^ES + exponent
  localparam int TE_BITS = 7;
  // largest total exponent, reached by maxpos
  localparam int TE_MAX  = (N - 2) << ES;

  typedef logic [N-1:0]              posit_t;
  typedef logic signed [TE_BITS-1:0] exponent_t;
  typedef logic [MANT_SIZE-1:0]      mant_t;
  typedef logic [RECIP_SIZE-1:0]     recip_t;
  typedef logic [NR_SIZE-1:0]        nr_recip_t;

  localparam posit_t NAR = {1'b1, {(N - 1){1'b0}}};

  typedef struct packed {
    logic      is_zero;
    logic      is_nar;
    logic      sign;
    exponent_t te;
    mant_t     mant;
  } posit_fields_t;

  // mant holds the hidden one at the top and one guard bit at the bottom
  typedef struct packed {
    logic               valid;
    logic               is_zero;
    logic               is_nar;
    logic               sign;
    exponent_t          te;
    logic [MANT_SIZE:0] mant;
    logic               sticky;
  } div_result_t;

endpackage

`default_nettype wire

//--- project.f
+incdir+testbench
design/ppu_pkg.sv
design/posit_decode.sv
design/mant_recip_seed.sv
design/newton_raphson.sv
design/core_div.sv
design/posit_encode.sv
design/posit_div_top.sv
testbench/tb_posit_div.sv

//--- testbench/posit_ref.svh
`ifndef POSIT_REF_SVH
`define POSIT_REF_SVH

`default_nettype none

function automatic real pow2(input int e);
  real v;
  v = 1.0;
  for (int i = 0; i < e; i++) begin
    v = v * 2.0;
  end
  for (int i = 0; i > e; i--) begin
    v = v / 2.0;
  end
  return v;
endfunction

// value of a positive n-bit posit pattern with es = 1
function automatic real posit_value(input logic [31:0] w, input int n);
  logic r;
  int   i;
  int   run;
  int   k;
  int   e;
  real  frac;
  real  scale;
  r   = w[n-2];
  i   = n - 2;
  run = 0;
  while (i >= 0 && w[i] == r) begin
    run++;
    i--;
  end
  // skip the regime terminator
  i--;
  k = r ? run - 1 : -run;
  e = 0;
  if (i >= 0) begin
    e = w[i];
    i--;
  end
  frac  = 1.0;
  scale = 0.5;
  while (i >= 0) begin
    if (w[i]) begin
      frac = frac + scale;
    end
    scale = scale * 0.5;
    i--;
  end
  return frac * pow2(2 * k + e);
endfunction

function automatic real posit_to_real(input ppu_pkg::posit_t p);
  ppu_pkg::posit_t mag;
  real             v;
  if (p == 16'h0000 || p == 16'h8000) begin
    return 0.0;
  end
  mag = p[15] ? -p : p;
  v   = posit_value({16'h0000, mag}, 16);
  return p[15] ? -v : v;
endfunction

// nearest posit, ties to the even pattern; no underflow to zero
function automatic ppu_pkg::posit_t nearest_posit(input real x);
  real             ax;
  real             m;
  int              lo;
  int              hi;
  int              mid;
  ppu_pkg::posit_t p;
  if (x == 0.0) begin
    return 16'h0000;
  end
  ax = (x < 0.0) ? -x : x;
  if (ax >= posit_value(32'h7FFF, 16)) begin
    p = 16'h7FFF;
  end else if (ax <= posit_value(32'h0001, 16)) begin
    p = 16'h0001;
  end else begin
    lo = 1;
    hi = 32'h7FFF;
    while (hi - lo > 1) begin
      mid = (lo + hi) / 2;
      if (posit_value(mid, 16) <= ax) begin
        lo = mid;
      end else begin
        hi = mid;
      end
    end
    // the 17-bit pattern between lo and hi is the rounding boundary
    m = posit_value((lo << 1) | 1, 17);
    if (ax > m) begin
      p = hi[15:0];
    end else if (ax < m) begin
      p = lo[15:0];
    end else begin
      p = lo[0] ? hi[15:0] : lo[15:0];
    end
  end
  if (x < 0.0) begin
    p = -p;
  end
  return p;
endfunction

// neighbours stay finite and non-zero
function automatic ppu_pkg::posit_t posit_next_up(input ppu_pkg::posit_t p);
  if (p == 16'h7FFF || p == 16'hFFFF) begin
    return p;
  end
  return p + 16'd1;
endfunction

function automatic ppu_pkg::posit_t posit_next_down(input ppu_pkg::posit_t p);
  if (p == 16'h8001 || p == 16'h0001) begin
    return p;
  end
  return p - 16'd1;
endfunction

// galois lfsr, x^32 + x^30 + x^26 + x^25 + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
endfunction

`default_nettype wire

`endif

//--- testbench/tb_posit_div.sv
`include "posit_ref.svh"

`default_nettype none

module tb_posit_div;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int LATENCY        = 3;
  localparam int TIMEOUT_CYCLES = 20;
  localparam int MAX_OPS        = 256;

  localparam ppu_pkg::posit_t ONE     = 16'h4000;
  localparam ppu_pkg::posit_t MAXPOS  = 16'h7FFF;
  localparam ppu_pkg::posit_t MINPOS  = 16'h0001;
  localparam ppu_pkg::posit_t NEG_MAX = 16'h8001;
  localparam ppu_pkg::posit_t NEG_MIN = 16'hFFFF;
  localparam ppu_pkg::posit_t NAR_W   = 16'h8000;

  logic            clk_i;
  logic            rst;
  logic            valid_i;
  ppu_pkg::posit_t dividend_i;
  ppu_pkg::posit_t divisor_i;
  logic            valid_o;
  ppu_pkg::posit_t quotient_o;

  ppu_pkg::posit_t op_a [MAX_OPS];
  ppu_pkg::posit_t op_b [MAX_OPS];
  ppu_pkg::posit_t exp_res [MAX_OPS];
  ppu_pkg::posit_t res [MAX_OPS];
  logic [31:0]     lfsr_state;
  int              mismatch_count;
  int              fail_count;

  posit_div_top i_posit_div_top (
    .clk_i      (clk_i),
    .rst        (rst),
    .valid_i    (valid_i),
    .dividend_i (dividend_i),
    .divisor_i  (divisor_i),
    .valid_o    (valid_o),
    .quotient_o (quotient_o)
  );

  always #20 clk_i = ~clk_i;

  task automatic check_posit(input string name, input ppu_pkg::posit_t got,
                             input ppu_pkg::posit_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
      mismatch_count++;
    end
  endtask

  task automatic check_valid(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s expected %b got %b", $time, name, exp, got);
      mismatch_count++;
    end
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    #2;
  endtask

  // one lfsr step per bit, zero and NaR are moved to finite values
  task automatic rand_finite(output ppu_pkg::posit_t p);
    for (int i = 0; i < 16; i++) begin
      p[i]       = lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
    end
    if (p == 16'h0000 || p == NAR_W) begin
      p = p ^ 16'h4000;
    end
  endtask

  task automatic load_op(input int i, input ppu_pkg::posit_t a, input ppu_pkg::posit_t b,
                         input ppu_pkg::posit_t e);
    op_a[i]    = a;
    op_b[i]    = b;
    exp_res[i] = e;
  endtask

  // back-to-back strobes, each result expected exactly LATENCY edges later
  task automatic run_batch(input int n);
    int edges;
    int got;
    int idx;
    int idle;
    edges = 0;
    got   = 0;
    idle  = 0;
    while (got < n && idle < TIMEOUT_CYCLES) begin
      if (edges < n) begin
        valid_i    = 1'b1;
        dividend_i = op_a[edges];
        divisor_i  = op_b[edges];
      end else begin
        valid_i = 1'b0;
        idle++;
      end
      next_cycle();
      edges++;
      idx = edges - LATENCY;
      check_valid("valid_o", valid_o, idx >= 0 && idx < n);
      if (valid_o && idx >= 0 && idx < n) begin
        res[idx] = quotient_o;
        got++;
      end
    end
    valid_i = 1'b0;
    if (got < n) begin
      $display("valid_o did not arrive for %0d of %0d operations within %0d cycles at %0t",
               n - got, n, TIMEOUT_CYCLES, $time);
      fail_count++;
    end
  endtask

  task automatic check_batch(input int n);
    for (int i = 0; i < n; i++) begin
      check_posit("quotient_o", res[i], exp_res[i]);
    end
  endtask

  // the correctly rounded quotient or one of its two neighbours
  task automatic check_accuracy(input ppu_pkg::posit_t a, input ppu_pkg::posit_t b,
                                input ppu_pkg::posit_t got);
    ppu_pkg::posit_t r;
    ppu_pkg::posit_t exp;
    r   = nearest_posit(posit_to_real(a) / posit_to_real(b));
    exp = (got == posit_next_up(r) || got == posit_next_down(r)) ? got : r;
    check_posit("quotient_o", got, exp);
  endtask

  task automatic test_reset_latency();
    ppu_pkg::posit_t a;
    for (int i = 0; i < 4; i++) begin
      next_cycle();
      check_valid("valid_o", valid_o, 1'b0);
      check_posit("quotient_o", quotient_o, 16'h0000);
    end
    load_op(0, ONE, ONE, ONE);
    run_batch(1);
    check_batch(1);
    // dividing by one returns each dividend, so order shows in the results
    for (int i = 0; i < 8; i++) begin
      rand_finite(a);
      load_op(i, a, ONE, a);
    end
    run_batch(8);
    check_batch(8);
  endtask

  task automatic test_specials();
    load_op(0, NAR_W, ONE, NAR_W);
    load_op(1, NAR_W, 16'h0000, NAR_W);
    load_op(2, NAR_W, NAR_W, NAR_W);
    load_op(3, NAR_W, NEG_MIN, NAR_W);
    load_op(4, 16'h5800, NAR_W, NAR_W);
    load_op(5, 16'h0000, NAR_W, NAR_W);
    load_op(6, 16'hC000, 16'h0000, NAR_W);
    load_op(7, MAXPOS, 16'h0000, NAR_W);
    load_op(8, 16'h0000, 16'h0000, NAR_W);
    load_op(9, 16'h0000, 16'h3A00, 16'h0000);
    load_op(10, 16'h0000, NEG_MAX, 16'h0000);
    load_op(11, 16'h0000, MINPOS, 16'h0000);
    run_batch(12);
    check_batch(12);
  endtask

  task automatic test_pow2();
    ppu_pkg::posit_t a;
    ppu_pkg::posit_t b;
    for (int i = 0; i < 32; i++) begin
      rand_finite(a);
      // 1, 2, 0.5 and -4
      case (i % 4)
        0: b = ONE;
        1: b = 16'h5000;
        2: b = 16'h3000;
        default: b = 16'hA000;
      endcase
      load_op(i, a, b, nearest_posit(posit_to_real(a) / posit_to_real(b)));
    end
    run_batch(32);
    check_batch(32);
  endtask

  task automatic test_sign();
    ppu_pkg::posit_t a;
    ppu_pkg::posit_t b;
    ppu_pkg::posit_t r0;
    ppu_pkg::posit_t neg_r0;
    for (int p = 0; p < 16; p++) begin
      rand_finite(a);
      rand_finite(b);
      a = a[15] ? -a : a;
      b = b[15] ? -b : b;
      load_op(4 * p, a, b, 16'h0000);
      load_op(4 * p + 1, -a, b, 16'h0000);
      load_op(4 * p + 2, a, -b, 16'h0000);
      load_op(4 * p + 3, -a, -b, 16'h0000);
    end
    run_batch(64);
    for (int p = 0; p < 16; p++) begin
      r0     = res[4 * p];
      neg_r0 = -r0;
      check_accuracy(op_a[4 * p], op_b[4 * p], r0);
      check_posit("quotient_o", res[4 * p + 1], neg_r0);
      check_posit("quotient_o", res[4 * p + 2], neg_r0);
      check_posit("quotient_o", res[4 * p + 3], r0);
    end
  endtask

  task automatic test_saturation();
    load_op(0, MAXPOS, MINPOS, MAXPOS);
    load_op(1, MINPOS, MAXPOS, MINPOS);
    load_op(2, NEG_MAX, MINPOS, NEG_MAX);
    load_op(3, MAXPOS, NEG_MIN, NEG_MAX);
    load_op(4, NEG_MIN, MAXPOS, NEG_MIN);
    load_op(5, MINPOS, NEG_MAX, NEG_MIN);
    load_op(6, NEG_MAX, NEG_MIN, MAXPOS);
    load_op(7, NEG_MIN, NEG_MAX, MINPOS);
    run_batch(8);
    check_batch(8);
  endtask

  task automatic test_random();
    ppu_pkg::posit_t a;
    ppu_pkg::posit_t b;
    for (int i = 0; i < 200; i++) begin
      rand_finite(a);
      rand_finite(b);
      load_op(i, a, b, 16'h0000);
    end
    run_batch(200);
    for (int i = 0; i < 200; i++) begin
      check_accuracy(op_a[i], op_b[i], res[i]);
    end
  endtask

  initial begin
    clk_i          = 1'b0;
    rst            = 1'b1;
    valid_i        = 1'b0;
    dividend_i     = '0;
    divisor_i      = '0;
    lfsr_state     = 32'h7499_7353;
    mismatch_count = 0;
    fail_count     = 0;
    repeat (8) @(posedge clk_i);
    #2;
    rst = 1'b0;

    test_reset_latency();
    test_specials();
    test_pow2();
    test_sign();
    test_saturation();
    test_random();

    $display("mismatches: %0d, other failures: %0d", mismatch_count, fail_count);
    if (mismatch_count == 0 && fail_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
